/* obj_params.svh */
// Raster and RAM sizes shared by RTL and testbench
// The frame is much shorter than a real board so that simulation stays short
// OBJ_AW must stay 10: the scan address is built from a 4-bit row and 6 hdump bits
// OBJ_CEN_DIV must be 2 or more
`ifndef OBJ_PARAMS_SVH
`define OBJ_PARAMS_SVH

// Word address width of the CPU RAM and the object table
`define OBJ_AW 10

// Pixels per line, hdump spans 0 to 255
`define OBJ_H_TOTAL 256
// Lines per frame
`define OBJ_V_TOTAL 32
// Visible lines, blank covers the rest
`define OBJ_V_ACTIVE 14
// Second-last line carries vload
`define OBJ_VLOAD_LINE 30

// clk cycles per pixel
`define OBJ_CEN_DIV 2

`endif

/* obj_pkg.sv */
// Types shared by the object buffer RTL and its testbench
// cpu_bus_t is a level bundle, a write happens on every clk with cs high and rnw low
`default_nettype none

`include "obj_params.svh"

package obj_pkg;

    // One object attribute word
    typedef logic [15:0] obj_word_t;

    // CPU access, sampled every clk
    typedef struct packed {
        logic [`OBJ_AW-1:0] addr;
        obj_word_t          din;
        // Active low, bit 1 is the upper byte
        logic [1:0]         dsn;
        logic               rnw;
        logic               cs;
    } cpu_bus_t;

    // Raster signals, all registered in the timing stage
    typedef struct packed {
        logic       pxl_cen;
        logic       lvbl;
        logic       vload;
        // Last pixel of the line, use with pxl_cen
        logic       hinit;
        logic [7:0] hdump;
    } vid_timing_t;

endpackage

`default_nettype wire

/* obj_dpram.sv */
// True dual-port RAM on a single clock with byte write enables
// Both reads are registered and return the old word on a write to the same address
// Writes to one word from both ports in the same clk give an undefined result
`default_nettype none

`include "obj_params.svh"

module obj_dpram
    import obj_pkg::*;
#(
    parameter int AW = `OBJ_AW
) (
    input  logic          clk,
    // Port 0
    input  logic [AW-1:0] addr0,
    input  obj_word_t     din0,
    input  logic [1:0]    we0,
    output obj_word_t     q0,
    // Port 1
    input  logic [AW-1:0] addr1,
    input  obj_word_t     din1,
    input  logic [1:0]    we1,
    output obj_word_t     q1
);

    obj_word_t mem [2**AW];

    always_ff @(posedge clk) begin
        // Lower byte lanes
        if (we0[0]) begin
            mem[addr0][7:0] <= din0[7:0];
        end
        if (we1[0]) begin
            mem[addr1][7:0] <= din1[7:0];
        end
        // Upper byte lanes
        if (we0[1]) begin
            mem[addr0][15:8] <= din0[15:8];
        end
        if (we1[1]) begin
            mem[addr1][15:8] <= din1[15:8];
        end
        // Read before write on both ports
        q0 <= mem[addr0];
        q1 <= mem[addr1];
    end

endmodule

`default_nettype wire

/* obj_vtiming.sv */
// Raster generator for the shortened OBJ_* frame
// All outputs are registered one clk behind the counters
// pxl_cen marks the last clk of each hdump value
`default_nettype none

`include "obj_params.svh"

module obj_vtiming
    import obj_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    output vid_timing_t vid
);

    localparam int CW = $clog2(`OBJ_CEN_DIV);
    localparam int VW = $clog2(`OBJ_V_TOTAL);

    logic [CW-1:0] cen_cnt;
    logic          cen;
    logic [7:0]    hcnt;
    logic [VW-1:0] vcnt;
    logic          h_last;
    logic          v_last;

    // Pixel enable on the last clk of each divider period
    assign cen    = cen_cnt == CW'(`OBJ_CEN_DIV - 1);
    assign h_last = hcnt == 8'(`OBJ_H_TOTAL - 1);
    assign v_last = vcnt == VW'(`OBJ_V_TOTAL - 1);

    // clk divider
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
        end else if (cen) begin
            cen_cnt <= '0;
        end else begin
            cen_cnt <= cen_cnt + 1'b1;
        end
    end

    // Pixel and line counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (cen) begin
            if (h_last) begin
                hcnt <= '0;
                // Frame wrap
                vcnt <= v_last ? '0 : vcnt + 1'b1;
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    // Output stage, reset to line 0 outside blank
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vid <= '{pxl_cen: 1'b0, lvbl: 1'b1, vload: 1'b0, hinit: 1'b0, hdump: 8'd0};
        end else begin
            vid.pxl_cen <= cen;
            // Blank from OBJ_V_ACTIVE to the end of frame
            vid.lvbl    <= vcnt < VW'(`OBJ_V_ACTIVE);
            vid.vload   <= vcnt == VW'(`OBJ_VLOAD_LINE);
            vid.hinit   <= h_last;
            vid.hdump   <= hcnt;
        end
    end

endmodule

`default_nettype wire

/* obj_buffer.sv */
// CPU object RAM plus the object table that the engine reads
// An armed copy runs from the first blank line, 64 words per line over 16 lines
// It stops after row 15 or at vload, whichever comes first
// CPU writes during a copy land in the CPU RAM only
`default_nettype none

`include "obj_params.svh"

module obj_buffer
    import obj_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  vid_timing_t        vid,
    input  cpu_bus_t           cpu,
    output obj_word_t          obj_dout,
    input  logic               obj_copy,
    input  logic [`OBJ_AW-1:0] tbl_addr,
    output obj_word_t          tbl_dout
);

    logic [1:0]         cpu_we;
    logic               lvbl_l;
    logic               vbl_start;
    logic               line_end;
    logic               copy_armed;
    logic               copy_run;
    logic [3:0]         copy_row;
    logic [`OBJ_AW-1:0] scan_addr;
    obj_word_t          scan_q;
    logic [1:0]         tbl_we;

    // Byte lane enables, dsn is active low
    assign cpu_we = ~({2{cpu.rnw}} | cpu.dsn) & {2{cpu.cs}};

    assign vbl_start = lvbl_l & ~vid.lvbl;
    assign line_end  = vid.hinit & vid.pxl_cen;

    // Group of 4 pixels per word, low pair reversed
    assign scan_addr = {copy_row, vid.hdump[7:4], ~vid.hdump[3:2]};

    // Whole word on every clk of the copy
    assign tbl_we = {2{copy_run}};

    // Copy control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l     <= 1'b1;
            copy_armed <= 1'b0;
            copy_run   <= 1'b0;
            copy_row   <= '0;
        end else begin
            lvbl_l <= vid.lvbl;
            // Request is consumed once the copy runs
            if (copy_run) begin
                copy_armed <= 1'b0;
            end else if (obj_copy) begin
                copy_armed <= 1'b1;
            end
            if (vid.vload) begin
                copy_run <= 1'b0;
            end else if (vbl_start) begin
                copy_run <= copy_armed;
            end else if (line_end && copy_row == 4'hf) begin
                // Last row done, keeps the row wrap out of the table
                copy_run <= 1'b0;
            end
            // One row per line, restarted at blank
            if (vbl_start) begin
                copy_row <= '0;
            end else if (line_end) begin
                copy_row <= copy_row + 1'b1;
            end
        end
    end

    // CPU side on port 0, scan read on port 1
    obj_dpram #(.AW(`OBJ_AW)) u_scan (
        .clk   (clk),
        .addr0 (cpu.addr),
        .din0  (cpu.din),
        .we0   (cpu_we),
        .q0    (obj_dout),
        .addr1 (scan_addr),
        .din1  (16'h0000),
        .we1   (2'b00),
        .q1    (scan_q)
    );

    // Copy writes on port 0, object engine reads on port 1
    obj_dpram #(.AW(`OBJ_AW)) u_table (
        .clk   (clk),
        .addr0 (scan_addr),
        .din0  (scan_q),
        .we0   (tbl_we),
        .q0    (),
        .addr1 (tbl_addr),
        .din1  (16'h0000),
        .we1   (2'b00),
        .q1    (tbl_dout)
    );

endmodule

`default_nettype wire

/* obj_top.sv */
// Object buffer top, raster stage feeding the buffer stage
// Single clock, the CPU bus is sampled on clk with no handshake
`default_nettype none

`include "obj_params.svh"

module obj_top
    import obj_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    // CPU access
    input  cpu_bus_t           cpu,
    output obj_word_t          obj_dout,
    // Copy request pulse
    input  logic               obj_copy,
    // Object engine read port
    input  logic [`OBJ_AW-1:0] tbl_addr,
    output obj_word_t          tbl_dout,
    // Raster, also used by the buffer
    output vid_timing_t        vid
);

    // Raster generator
    obj_vtiming u_vtiming (
        .clk (clk),
        .rst (rst),
        .vid (vid)
    );

    // RAMs and copy engine
    obj_buffer u_buffer (
        .clk      (clk),
        .rst      (rst),
        .vid      (vid),
        .cpu      (cpu),
        .obj_dout (obj_dout),
        .obj_copy (obj_copy),
        .tbl_addr (tbl_addr),
        .tbl_dout (tbl_dout)
    );

endmodule

`default_nettype wire

/* obj_assert.sv */
// Copy control checks, bound into every obj_buffer
// Relies on the internal names tbl_we, copy_run and copy_armed
`default_nettype none

module obj_assert
    import obj_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input vid_timing_t vid,
    input logic [1:0]  tbl_we,
    input logic        copy_run,
    input logic        copy_armed
);

    // Number of failed assertions
    int unsigned fail_count = 0;

    // Table writes only inside vertical blank
    a_write_in_blank: assert property (
        @(posedge clk) disable iff (rst) (|tbl_we) |-> !vid.lvbl
    ) else begin
        fail_count++;
        $error("object table written while lvbl is high");
    end

    // vload always ends a copy
    a_stop_at_vload: assert property (
        @(posedge clk) disable iff (rst) vid.vload |=> !copy_run
    ) else begin
        fail_count++;
        $error("copy still running in the clk after vload");
    end

    // Request consumed by the copy it started
    a_arm_consumed: assert property (
        @(posedge clk) disable iff (rst) $rose(copy_run) |=> !copy_armed
    ) else begin
        fail_count++;
        $error("copy request still armed after the copy started");
    end

endmodule

bind obj_buffer obj_assert u_obj_assert (
    .clk        (clk),
    .rst        (rst),
    .vid        (vid),
    .tbl_we     (tbl_we),
    .copy_run   (copy_run),
    .copy_armed (copy_armed)
);

`default_nettype wire

/* obj_tb.sv */
// Directed testbench for obj_top, single clk with CPU bus driven 1 time unit after posedge
// Outputs are sampled on the falling edge, the table shadow follows the CPU shadow at each copy
// Assumes no CPU writes while a copy runs
`default_nettype none

`include "obj_params.svh"

module obj_tb
    import obj_pkg::*;
();

    localparam int AW         = `OBJ_AW;
    localparam int FRAME_CLKS = `OBJ_V_TOTAL * `OBJ_H_TOTAL * `OBJ_CEN_DIV;
    localparam int WAIT_LIMIT = 2 * FRAME_CLKS;

    logic        clk = 1'b0;
    logic        rst;
    cpu_bus_t    cpu;
    obj_word_t   obj_dout;
    logic        obj_copy;
    logic [AW-1:0] tbl_addr;
    obj_word_t   tbl_dout;
    vid_timing_t vid;

    // Shadow of the CPU RAM and of the object table
    obj_word_t   cpu_mem [2**AW];
    obj_word_t   tbl_mem [2**AW];
    int          checks = 0;
    int          errors = 0;

    obj_top u_obj_top (
        .clk      (clk),
        .rst      (rst),
        .cpu      (cpu),
        .obj_dout (obj_dout),
        .obj_copy (obj_copy),
        .tbl_addr (tbl_addr),
        .tbl_dout (tbl_dout),
        .vid      (vid)
    );

    always #5 clk = ~clk;

    task automatic finish_run();
        int unsigned assert_fails;
        // Failed assertions of the bound copy checker
        assert_fails = u_obj_top.u_buffer.u_obj_assert.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s", what);
        errors++;
        finish_run();
    endtask

    task automatic check_word(input string name, input obj_word_t got, input obj_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_vid(input string name, input vid_timing_t got, input vid_timing_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail %s: got %h exp %h", name, got, exp);
        end
    endtask

    // 0 is blank, 1 is active video, anything else is vload
    function automatic logic level_of(input int which);
        case (which)
            0: return !vid.lvbl;
            1: return vid.lvbl;
            default: return vid.vload;
        endcase
    endfunction

    task automatic watch_rise(input int which, input string what);
        logic prev;
        logic cur;
        int   n;
        n = 0;
        @(negedge clk);
        cur = level_of(which);
        do begin
            prev = cur;
            @(negedge clk);
            cur = level_of(which);
            n++;
        end while (!(cur && !prev) && n < WAIT_LIMIT);
        if (!(cur && !prev)) begin
            timeout_fail(what);
        end
    endtask

    task automatic wait_vblank_start();
        watch_rise(0, "start of vertical blank");
    endtask

    task automatic wait_frame_start();
        watch_rise(1, "end of vertical blank");
    endtask

    task automatic wait_vload();
        watch_rise(2, "vload");
    endtask

    task automatic cpu_write(input logic [AW-1:0] addr, input obj_word_t data,
                             input logic [1:0] dsn);
        @(posedge clk);
        #1;
        cpu = '{addr: addr, din: data, dsn: dsn, rnw: 1'b0, cs: 1'b1};
        @(posedge clk);
        #1;
        cpu.cs  = 1'b0;
        cpu.rnw = 1'b1;
        // Only lanes with a low strobe change
        if (!dsn[0]) begin
            cpu_mem[addr][7:0] = data[7:0];
        end
        if (!dsn[1]) begin
            cpu_mem[addr][15:8] = data[15:8];
        end
    endtask

    task automatic cpu_read(input logic [AW-1:0] addr, output obj_word_t data);
        @(posedge clk);
        #1;
        cpu = '{addr: addr, din: 16'h0000, dsn: 2'b11, rnw: 1'b1, cs: 1'b1};
        @(posedge clk);
        @(negedge clk);
        data = obj_dout;
    endtask

    task automatic tbl_read(input logic [AW-1:0] addr, output obj_word_t data);
        @(posedge clk);
        #1;
        tbl_addr = addr;
        @(posedge clk);
        @(negedge clk);
        data = tbl_dout;
    endtask

    task automatic pulse_copy();
        @(posedge clk);
        #1;
        obj_copy = 1'b1;
        @(posedge clk);
        #1;
        obj_copy = 1'b0;
    endtask

    task automatic scramble_cpu(input int n);
        repeat (n) begin
            cpu_write(AW'($urandom()), 16'($urandom()), 2'b00);
        end
    endtask

    task automatic check_table();
        obj_word_t got;
        for (int i = 0; i < 2**AW; i++) begin
            tbl_read(AW'(i), got);
            check_word($sformatf("tbl_dout[%03h]", i), got, tbl_mem[i]);
        end
    endtask

    // One frame from line 0, expected raster built from pixel, phase and line counts
    task automatic raster_test();
        vid_timing_t exp;
        int p;
        int ph;
        int line;
        int cen_count;
        int lines;
        wait_frame_start();
        p = 0;
        ph = 0;
        line = 0;
        cen_count = 0;
        lines = 0;
        repeat (FRAME_CLKS) begin
            exp = '{pxl_cen: ph == `OBJ_CEN_DIV - 1, lvbl: line < `OBJ_V_ACTIVE,
                    vload: line == `OBJ_VLOAD_LINE, hinit: p == `OBJ_H_TOTAL - 1,
                    hdump: p[7:0]};
            check_vid("vid", vid, exp);
            if (vid.pxl_cen) begin
                cen_count++;
            end
            // Line end as the DUT reports it
            if (vid.pxl_cen && vid.hinit) begin
                check_count("pxl_cen per line", cen_count, `OBJ_H_TOTAL);
                cen_count = 0;
                lines++;
            end
            if (ph == `OBJ_CEN_DIV - 1) begin
                ph = 0;
                if (p == `OBJ_H_TOTAL - 1) begin
                    p = 0;
                    line++;
                end else begin
                    p++;
                end
            end else begin
                ph++;
            end
            @(negedge clk);
        end
        check_count("lines per frame", lines, `OBJ_V_TOTAL);
    endtask

    task automatic byte_lane_test();
        logic [AW-1:0] addr [16];
        logic [1:0]    dsn;
        obj_word_t     got;
        for (int i = 0; i < 16; i++) begin
            addr[i] = AW'($urandom());
            cpu_write(addr[i], 16'($urandom()), 2'b00);
        end
        // Lower lane, upper lane, then no lane
        for (int i = 0; i < 16; i++) begin
            case (i % 3)
                0: dsn = 2'b10;
                1: dsn = 2'b01;
                default: dsn = 2'b11;
            endcase
            cpu_write(addr[i], 16'($urandom()), dsn);
        end
        for (int i = 0; i < 16; i++) begin
            cpu_read(addr[i], got);
            check_word($sformatf("obj_dout[%03h]", addr[i]), got, cpu_mem[addr[i]]);
        end
    endtask

    task automatic full_copy_test();
        for (int i = 0; i < 2**AW; i++) begin
            cpu_write(AW'(i), 16'($urandom()), 2'b00);
        end
        // Arm during active video
        wait_frame_start();
        pulse_copy();
        wait_vblank_start();
        wait_vload();
        tbl_mem = cpu_mem;
        check_table();
    endtask

    task automatic no_request_test();
        scramble_cpu(64);
        wait_vblank_start();
        wait_vload();
        check_table();
    endtask

    task automatic arm_consumed_test();
        pulse_copy();
        wait_vblank_start();
        wait_vload();
        tbl_mem = cpu_mem;
        check_table();
        // Second frame must not copy again
        scramble_cpu(64);
        wait_vblank_start();
        wait_vload();
        check_table();
    endtask

    initial begin
        void'($urandom(32'h8c79));
        rst = 1'b1;
        cpu = '{addr: '0, din: 16'h0000, dsn: 2'b11, rnw: 1'b1, cs: 1'b0};
        obj_copy = 1'b0;
        tbl_addr = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        raster_test();
        byte_lane_test();
        full_copy_test();
        no_request_test();
        arm_consumed_test();
        finish_run();
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
obj_pkg.sv
obj_dpram.sv
obj_vtiming.sv
obj_buffer.sv
obj_top.sv
obj_assert.sv
obj_tb.sv

/* Bender.yml */
package:
  name: obj_buffer

export_include_dirs:
  - .

sources:
  # Design, in compile order
  - obj_pkg.sv
  - obj_dpram.sv
  - obj_vtiming.sv
  - obj_buffer.sv
  - obj_top.sv
  # Bound assertions and testbench
  - target: test
    files:
      - obj_assert.sv
      - obj_tb.sv
